// ==== build.f ====
+incdir+test
hw/cam_pkg.sv
hw/cam_raw10_unpack.sv
hw/cam_capture_ctrl.sv
hw/cam_dma_fifo.sv
hw/cam_dma_writer.sv
hw/cam_stats.sv
hw/cam_capture_top.sv
test/tb_cam_capture.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the camera capture testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass message.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_cam_capture \
   -Mdir "$BUILD_DIR" -o tb_cam_capture
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/tb_cam_capture" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

// ==== test/tb_cam_tasks.svh ====
//////////////////////////////
// Frame driver, DMA burst control, capture model and the directed
// tests. Included inside the testbench top module.
//////////////////////////////

task automatic apply_reset();
   rst_n           = 1'b0;
   i_mipi          = '0;
   i_trigger       = 1'b0;
   i_continuous    = 1'b0;
   i_dma_init_done = 1'b0;
   wready_lvl      = 1'b0;
   bp_on           = 1'b0;
   cap_active      = 1'b0;
   trig_pending    = 1'b0;
   cont_on         = 1'b0;
   wr_total        = 0;
   exp_q.delete();
   repeat (3) @(negedge mipi_pclk);
   rst_n = 1'b1;
endtask

task automatic pulse_trigger();
   @(negedge mipi_pclk);
   i_trigger = 1'b1;
   repeat (2) @(negedge mipi_pclk);
   i_trigger = 1'b0;
   // Synchronizer and edge detect before the hold is set
   repeat (3) @(negedge mipi_pclk);
   trig_pending = 1'b1;
endtask

task automatic enable_continuous();
   @(negedge mipi_pclk);
   i_continuous = 1'b1;
   repeat (4) @(negedge mipi_pclk);
   cont_on = 1'b1;
endtask

// One frame of n_raw RAW10 words with n_junk other words mixed in
task automatic send_frame(input int n_raw, input int n_junk);
   logic [63:0]           data;
   logic [PIX_WORD_W-1:0] exp_word;
   bit                    captured;
   bit                    junk;
   int                    junk_left;
   captured  = cap_active;
   junk_left = n_junk;
   @(negedge mipi_pclk);
   i_mipi    = '0;
   i_mipi.vs = 1'b1;
   repeat (2) @(negedge mipi_pclk);
   for (int i = 0; i < n_raw + n_junk; i++) begin
      junk = (junk_left > 0) && (i % 2 == 1);
      data = {$random(pix_seed), $random(pix_seed)};
      @(negedge mipi_pclk);
      i_mipi.data  = data;
      // Embedded data type, not RAW10
      i_mipi.dtype = junk ? 6'h12 : RAW10_DT;
      i_mipi.valid = 1'b1;
      i_mipi.hs    = 1'b1;
      if (junk) begin
         junk_left--;
      end else if (captured) begin
         // Upper 8 bits of each 10-bit pixel, pixel 0 in the low byte
         for (int p = 0; p < PPC; p++) begin
            exp_word[p*8 +: 8] = data[p*10 + 2 +: 8];
         end
         exp_q.push_back(exp_word);
         wr_total     = wr_total + 1;
         trig_pending = 1'b0;
      end
   end
   @(negedge mipi_pclk);
   i_mipi = '0;
   // Frame end opens or closes the capture
   cap_active = trig_pending || cont_on;
   repeat (FRAME_GAP) @(negedge mipi_pclk);
endtask

task automatic wait_beats(input int unsigned target);
   int unsigned waited;
   waited = 0;
   while (beat_total < target && waited < BEAT_TIMEOUT) begin
      @(negedge mipi_pclk);
      waited++;
   end
   if (beat_total < target) report_error("Timed out waiting for DMA beats");
endtask

task automatic pulse_init_done();
   @(negedge mipi_pclk);
   i_dma_init_done = 1'b1;
   repeat (2) @(negedge mipi_pclk);
   i_dma_init_done = 1'b0;
endtask

// One init-done pulse per burst
task automatic run_bursts(input int n_bursts);
   int unsigned target;
   for (int b = 0; b < n_bursts; b++) begin
      target = beat_total + DMA_LEN;
      pulse_init_done();
      wait_beats(target);
   end
endtask

////////// Directed tests //////////
task automatic test_reset_values();
   @(negedge mipi_pclk);
   check_value("o_dma_wvalid", 64'(o_dma_wvalid), 64'(0));
   check_value("o_dma_wlast", 64'(o_dma_wlast), 64'(0));
   check_value("o_fifo_overflow", 64'(o_fifo_overflow), 64'(0));
   check_value("o_fifo_underflow", 64'(o_fifo_underflow), 64'(0));
   check_value("o_wr_count", 64'(o_wr_count), 64'(0));
   check_value("o_beat_count", 64'(o_beat_count), 64'(0));
   check_value("o_fps", 64'(o_fps), 64'(0));
endtask

task automatic test_idle_frames();
   // Ready high and a burst armed, so a stray FIFO write shows up as a beat
   wready_lvl = 1'b1;
   pulse_init_done();
   repeat (2) send_frame(8, 0);
   check_value("o_wr_count", 64'(o_wr_count), 64'(0));
   check_value("beat_total", 64'(beat_total), 64'(0));
endtask

task automatic test_single_trigger();
   wready_lvl = 1'b1;
   fork
      begin
         pulse_trigger();
         repeat (3) send_frame(16, 4);
      end
      run_bursts(2);
   join
   check_value("pending_words", 64'(exp_q.size()), 64'(0));
   check_value("o_wr_count", 64'(o_wr_count), 64'(16));
   check_value("o_beat_count", 64'(o_beat_count), 64'(16));
endtask

task automatic test_continuous_backpressure();
   bp_on = 1'b1;
   fork
      begin
         enable_continuous();
         repeat (4) send_frame(8, 2);
      end
      run_bursts(3);
   join
   bp_on = 1'b0;
   check_value("pending_words", 64'(exp_q.size()), 64'(0));
   check_value("o_wr_count", 64'(o_wr_count), 64'(wr_total));
   check_value("o_beat_count", 64'(o_beat_count), 64'(wr_total));
   check_value("o_fifo_overflow", 64'(o_fifo_overflow), 64'(0));
   check_value("o_fifo_underflow", 64'(o_fifo_underflow), 64'(0));
endtask

task automatic test_overflow();
   apply_reset();
   pulse_trigger();
   send_frame(2, 0);
   send_frame(FIFO_DEPTH + 4, 0);
   check_value("o_wr_count", 64'(o_wr_count), 64'(wr_total));
   check_value("o_dma_wvalid", 64'(o_dma_wvalid), 64'(0));
   check_value("o_fifo_overflow", 64'(o_fifo_overflow), 64'(1));
   // Sticky flag
   repeat (20) @(negedge mipi_pclk);
   check_value("o_fifo_overflow", 64'(o_fifo_overflow), 64'(1));
endtask

task automatic test_frame_rate();
   int unsigned waited;
   apply_reset();
   // Three short frames all end well inside the first window
   repeat (3) send_frame(2, 0);
   waited = 0;
   while (o_fps == 0 && waited < 3 * FPS_WINDOW) begin
      @(negedge mipi_pclk);
      waited++;
   end
   if (o_fps == 0) report_error("Timed out waiting for the FPS window to close");
   check_value("o_fps", 64'(o_fps), 64'(3));
endtask

// ==== test/tb_cam_capture.sv ====
//////////////////////////////
// Testbench for the camera capture path. Sends MIPI frames, models
// the capture rules and acts as the DMA sink that checks each beat.
//////////////////////////////

module tb_cam_capture;
   import cam_pkg::*;

   localparam int unsigned DMA_LEN      = 8;
   localparam int unsigned FIFO_DEPTH   = 16;
   localparam int unsigned FPS_WINDOW   = 400;
   localparam int unsigned FRAME_GAP    = 12;
   localparam int unsigned BEAT_TIMEOUT = 2000;
   localparam integer      SEED         = 32'hb86b_1072;

   logic                  mipi_pclk = 1'b0;
   logic                  rst_n;
   mipi_in_s              i_mipi;
   logic                  i_trigger;
   logic                  i_continuous;
   logic                  i_dma_init_done;
   logic                  i_dma_wready;
   logic                  o_dma_wvalid;
   logic                  o_dma_wlast;
   logic [DMA_DATA_W-1:0] o_dma_wdata;
   logic                  o_fifo_overflow;
   logic                  o_fifo_underflow;
   logic [CNT_W-1:0]      o_wr_count;
   logic [CNT_W-1:0]      o_beat_count;
   logic [CNT_W-1:0]      o_fps;

   // Reference model state
   logic [PIX_WORD_W-1:0] exp_q [$];
   logic [PIX_WORD_W-1:0] sink_word;
   int unsigned           beat_total;
   int unsigned           wr_total;
   bit                    cap_active;
   bit                    trig_pending;
   bit                    cont_on;
   integer                pix_seed = SEED;
   integer                bp_seed  = SEED;

   // Fixed ready level, or random back-pressure while bp_on is set
   logic                  wready_lvl;
   logic                  bp_on;
   logic                  bp_rand = 1'b1;

   assign i_dma_wready = bp_on ? bp_rand : wready_lvl;

   cam_capture_top #(
      .DMA_LEN    (DMA_LEN),
      .FIFO_DEPTH (FIFO_DEPTH),
      .FPS_WINDOW (FPS_WINDOW)
   ) u_dut (
      .mipi_pclk        (mipi_pclk),
      .rst_n            (rst_n),
      .i_mipi           (i_mipi),
      .i_trigger        (i_trigger),
      .i_continuous     (i_continuous),
      .i_dma_init_done  (i_dma_init_done),
      .i_dma_wready     (i_dma_wready),
      .o_dma_wvalid     (o_dma_wvalid),
      .o_dma_wlast      (o_dma_wlast),
      .o_dma_wdata      (o_dma_wdata),
      .o_fifo_overflow  (o_fifo_overflow),
      .o_fifo_underflow (o_fifo_underflow),
      .o_wr_count       (o_wr_count),
      .o_beat_count     (o_beat_count),
      .o_fps            (o_fps)
   );

   always #10 mipi_pclk = ~mipi_pclk;

   // Ready is high about three cycles in four
   always @(negedge mipi_pclk) begin
      bp_rand <= ($random(bp_seed) & 3) != 0;
   end

   ////////// DMA sink //////////
   always @(posedge mipi_pclk) begin
      if (!rst_n) begin
         beat_total = 0;
      end else if (o_dma_wvalid && i_dma_wready) begin
         if (exp_q.size() == 0) begin
            report_error("DMA beat arrived while no captured word was pending");
         end else begin
            sink_word = exp_q.pop_front();
            check_value("o_dma_wdata", o_dma_wdata, {32'h0, sink_word});
            // Last flag on beat DMA_LEN-1 of every burst
            check_value("o_dma_wlast", 64'(o_dma_wlast),
                        64'((beat_total % DMA_LEN) == (DMA_LEN - 1)));
            beat_total = beat_total + 1;
         end
      end
   end

   task automatic stop_failed();
      $display("Simulation FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic report_error(input string why);
      $display("ERROR: %s", why);
      stop_failed();
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         stop_failed();
      end
   endtask

   `include "tb_cam_tasks.svh"

   initial begin
      apply_reset();
      test_reset_values();
      test_idle_frames();
      test_single_trigger();
      test_continuous_backpressure();
      test_overflow();
      test_frame_rate();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== hw/cam_capture_top.sv ====
//////////////////////////////
// Camera capture path top level. RAW10 in from the MIPI receiver,
// packed 8-bit pixels out over the DMA write port, plus statistics.
//////////////////////////////

module cam_capture_top #(
   parameter int unsigned DMA_LEN    = 1920,
   parameter int unsigned FIFO_DEPTH = 512,
   parameter int unsigned FPS_WINDOW = 100000000
) (
   input  logic                           mipi_pclk,
   input  logic                           rst_n,
   input  cam_pkg::mipi_in_s              i_mipi,
   input  logic                           i_trigger,
   input  logic                           i_continuous,
   input  logic                           i_dma_init_done,
   input  logic                           i_dma_wready,
   // DMA write port
   output logic                           o_dma_wvalid,
   output logic                           o_dma_wlast,
   output logic [cam_pkg::DMA_DATA_W-1:0] o_dma_wdata,
   // Statistics
   output logic                           o_fifo_overflow,
   output logic                           o_fifo_underflow,
   output logic [cam_pkg::CNT_W-1:0]      o_wr_count,
   output logic [cam_pkg::CNT_W-1:0]      o_beat_count,
   output logic [cam_pkg::CNT_W-1:0]      o_fps
);
   import cam_pkg::*;

   pix_word_s             pix;
   logic                  frame_end;
   logic                  capture;
   logic                  fifo_wr;
   logic                  fifo_rd;
   logic [PIX_WORD_W-1:0] fifo_rdata;
   logic                  fifo_empty;
   logic                  fifo_overflow;
   logic                  fifo_underflow;
   stat_evt_s             evt;

   cam_raw10_unpack u_unpack (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .i_mipi      (i_mipi),
      .o_pix       (pix),
      .o_frame_end (frame_end)
   );

   cam_capture_ctrl u_capture_ctrl (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .i_trigger    (i_trigger),
      .i_continuous (i_continuous),
      .i_frame_end  (frame_end),
      .i_fifo_wr    (fifo_wr),
      .o_capture    (capture)
   );

   // Words only enter the FIFO during a capture
   assign fifo_wr = pix.valid & capture;

   cam_dma_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_dma_fifo (
      .mipi_pclk   (mipi_pclk),
      .rst_n       (rst_n),
      .i_wr        (fifo_wr),
      .i_wdata     (pix.data),
      .i_rd        (fifo_rd),
      .o_rdata     (fifo_rdata),
      .o_empty     (fifo_empty),
      .o_overflow  (fifo_overflow),
      .o_underflow (fifo_underflow)
   );

   cam_dma_writer #(
      .DMA_LEN (DMA_LEN)
   ) u_dma_writer (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .i_init_done  (i_dma_init_done),
      .i_fifo_empty (fifo_empty),
      .i_fifo_rdata (fifo_rdata),
      .i_dma_wready (i_dma_wready),
      .o_fifo_rd    (fifo_rd),
      .o_dma_wvalid (o_dma_wvalid),
      .o_dma_wlast  (o_dma_wlast),
      .o_dma_wdata  (o_dma_wdata)
   );

   ////////// Statistics //////////
   assign evt.fifo_wr        = fifo_wr;
   assign evt.dma_beat       = fifo_rd;
   assign evt.fifo_overflow  = fifo_overflow;
   assign evt.fifo_underflow = fifo_underflow;
   assign evt.frame_end      = frame_end;

   cam_stats #(
      .FPS_WINDOW (FPS_WINDOW)
   ) u_stats (
      .mipi_pclk        (mipi_pclk),
      .rst_n            (rst_n),
      .i_evt            (evt),
      .o_fifo_overflow  (o_fifo_overflow),
      .o_fifo_underflow (o_fifo_underflow),
      .o_wr_count       (o_wr_count),
      .o_beat_count     (o_beat_count),
      .o_fps            (o_fps)
   );

endmodule

// ==== hw/cam_stats.sv ====
//////////////////////////////
// Debug counters for firmware. Sticky FIFO error flags, write and
// beat counts, and frames per FPS_WINDOW clocks.
//////////////////////////////

module cam_stats #(
   parameter int unsigned FPS_WINDOW = 100000000
) (
   input  logic                      mipi_pclk,
   input  logic                      rst_n,
   input  cam_pkg::stat_evt_s        i_evt,
   output logic                      o_fifo_overflow,
   output logic                      o_fifo_underflow,
   output logic [cam_pkg::CNT_W-1:0] o_wr_count,
   output logic [cam_pkg::CNT_W-1:0] o_beat_count,
   output logic [cam_pkg::CNT_W-1:0] o_fps
);
   import cam_pkg::*;

   localparam logic [CNT_W-1:0] WIN_LAST = CNT_W'(FPS_WINDOW - 1);

   logic [CNT_W-1:0] timer;
   logic [CNT_W-1:0] frame_cnt;
   logic             window_end;

   assign window_end = (timer == WIN_LAST);

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         o_fifo_overflow  <= 1'b0;
         o_fifo_underflow <= 1'b0;
         o_wr_count       <= '0;
         o_beat_count     <= '0;
         o_fps            <= '0;
         timer            <= '0;
         frame_cnt        <= '0;
      end else begin
         if (i_evt.fifo_overflow) begin
            o_fifo_overflow <= 1'b1;
         end
         if (i_evt.fifo_underflow) begin
            o_fifo_underflow <= 1'b1;
         end
         if (i_evt.fifo_wr) begin
            o_wr_count <= o_wr_count + 1'b1;
         end
         if (i_evt.dma_beat) begin
            o_beat_count <= o_beat_count + 1'b1;
         end

         ////////// FPS window //////////
         if (window_end) begin
            timer     <= '0;
            frame_cnt <= '0;
            // A frame end in the closing cycle still belongs to this window
            o_fps     <= frame_cnt + CNT_W'(i_evt.frame_end);
         end else begin
            timer <= timer + 1'b1;
            if (i_evt.frame_end) begin
               frame_cnt <= frame_cnt + 1'b1;
            end
         end
      end
   end

endmodule

// ==== hw/cam_dma_writer.sv ====
//////////////////////////////
// DMA write side. Each init-done rising edge arms one burst of
// DMA_LEN beats, drained from the FIFO over valid/ready.
//////////////////////////////

module cam_dma_writer #(
   parameter int unsigned DMA_LEN = 1920
) (
   input  logic                           mipi_pclk,
   input  logic                           rst_n,
   input  logic                           i_init_done,
   input  logic                           i_fifo_empty,
   input  logic [cam_pkg::PIX_WORD_W-1:0] i_fifo_rdata,
   input  logic                           i_dma_wready,
   output logic                           o_fifo_rd,
   output logic                           o_dma_wvalid,
   output logic                           o_dma_wlast,
   output logic [cam_pkg::DMA_DATA_W-1:0] o_dma_wdata
);
   import cam_pkg::*;

   localparam int unsigned CW         = (DMA_LEN > 1) ? $clog2(DMA_LEN) : 1;
   localparam logic [CW-1:0] LAST_BEAT = CW'(DMA_LEN - 1);

   logic          init_r1;
   logic          init_r2;
   logic          init_r3;
   logic          armed;
   logic [CW-1:0] beat_cnt;
   logic          beat;

   assign o_dma_wvalid = armed & ~i_fifo_empty;
   assign beat         = o_dma_wvalid & i_dma_wready;
   assign o_fifo_rd    = beat;
   assign o_dma_wlast  = o_dma_wvalid & (beat_cnt == LAST_BEAT);

   // Packed pixels in the low half of the beat
   assign o_dma_wdata  = {{(DMA_DATA_W - PIX_WORD_W){1'b0}}, i_fifo_rdata};

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_r1  <= 1'b0;
         init_r2  <= 1'b0;
         init_r3  <= 1'b0;
         armed    <= 1'b0;
         beat_cnt <= '0;
      end else begin
         init_r1 <= i_init_done;
         init_r2 <= init_r1;
         init_r3 <= init_r2;

         if (init_r2 & ~init_r3) begin
            armed <= 1'b1;
         end else if (beat & o_dma_wlast) begin
            armed <= 1'b0;
         end

         // Beat index within the burst, wraps after the last one
         if (beat) begin
            beat_cnt <= o_dma_wlast ? '0 : beat_cnt + 1'b1;
         end
      end
   end

endmodule

// ==== hw/cam_dma_fifo.sv ====
//////////////////////////////
// Single-clock FIFO between the pixel packer and the DMA writer.
// First-word-fall-through: the head word sits on o_rdata whenever
// o_empty is low. Bad writes and reads pulse the error outputs.
//////////////////////////////

module cam_dma_fifo #(
   parameter int unsigned DEPTH = 512
) (
   input  logic                           mipi_pclk,
   input  logic                           rst_n,
   input  logic                           i_wr,
   input  logic [cam_pkg::PIX_WORD_W-1:0] i_wdata,
   input  logic                           i_rd,
   output logic [cam_pkg::PIX_WORD_W-1:0] o_rdata,
   output logic                           o_empty,
   output logic                           o_overflow,
   output logic                           o_underflow
);
   import cam_pkg::*;

   localparam int unsigned AW        = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);
   localparam logic [AW:0]   FULL_CNT = (AW + 1)'(DEPTH);

   logic [PIX_WORD_W-1:0] mem [DEPTH];
   logic [AW-1:0]         wr_ptr;
   logic [AW-1:0]         rd_ptr;
   logic [AW:0]           count;
   logic                  full;
   logic                  wr_ok;
   logic                  rd_ok;

   // Pointer wrap also for depths that are not a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
   endfunction

   assign full    = (count == FULL_CNT);
   assign o_empty = (count == '0);
   assign wr_ok   = i_wr & ~full;
   assign rd_ok   = i_rd & ~o_empty;

   // Head of the queue, readable one cycle after its write
   assign o_rdata = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= i_wdata;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         o_overflow  <= 1'b0;
         o_underflow <= 1'b0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_ok) begin
            rd_ptr <= next_ptr(rd_ptr);
         end

         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase

         // A write into a full FIFO loses its word
         o_overflow  <= i_wr & full;
         o_underflow <= i_rd & o_empty;
      end
   end

endmodule

// ==== hw/cam_capture_ctrl.sv ====
//////////////////////////////
// Capture gate. Synchronizes the firmware trigger and continuous
// requests and opens or closes capture on frame boundaries only.
//////////////////////////////

module cam_capture_ctrl (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic i_trigger,
   input  logic i_continuous,
   input  logic i_frame_end,
   input  logic i_fifo_wr,
   output logic o_capture
);

   logic trig_r1;
   logic trig_r2;
   logic trig_r3;
   logic trig_hold;
   logic cont_r1;
   logic cont_r2;
   logic cont_hold;
   logic capture;
   logic trig_rise;

   assign trig_rise = trig_r2 & ~trig_r3;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         trig_r1   <= 1'b0;
         trig_r2   <= 1'b0;
         trig_r3   <= 1'b0;
         trig_hold <= 1'b0;
         cont_r1   <= 1'b0;
         cont_r2   <= 1'b0;
         cont_hold <= 1'b0;
         capture   <= 1'b0;
      end else begin
         trig_r1 <= i_trigger;
         trig_r2 <= trig_r1;
         trig_r3 <= trig_r2;
         cont_r1 <= i_continuous;
         cont_r2 <= cont_r1;

         // Hold the request until the capture has really started writing
         if (trig_rise) begin
            trig_hold <= 1'b1;
         end else if (i_fifo_wr) begin
            trig_hold <= 1'b0;
         end

         // Continuous mode stays on until reset
         if (cont_r2) begin
            cont_hold <= 1'b1;
         end

         ////////// Frame gating //////////
         if ((trig_hold | cont_hold) & i_frame_end) begin
            capture <= 1'b1;
         end else if (capture & i_frame_end & ~cont_hold) begin
            capture <= 1'b0;
         end
      end
   end

   assign o_capture = capture;

endmodule

// ==== hw/cam_raw10_unpack.sv ====
//////////////////////////////
// Front end of the capture path. Registers the MIPI word, keeps
// RAW10 words only and packs the upper 8 bits of four pixels.
// Also flags the end of each frame on the vsync falling edge.
//////////////////////////////

module cam_raw10_unpack (
   input  logic               mipi_pclk,
   input  logic               rst_n,
   input  cam_pkg::mipi_in_s  i_mipi,
   output cam_pkg::pix_word_s o_pix,
   output logic               o_frame_end
);
   import cam_pkg::*;

   logic [PIX_WORD_W-1:0] pix8;
   pix_word_s             pix_q;
   logic                  vs_q;
   logic                  vs_q2;

   // Bits 9:2 of every pixel, pixel 0 lands in the low byte
   for (genvar p = 0; p < PPC; p++) begin : g_pix
      assign pix8[p*PIX_BITS +: PIX_BITS] =
         i_mipi.data[p*RAW_BITS + RAW_BITS - 1 -: PIX_BITS];
   end

   always_ff @(posedge mipi_pclk) begin
      pix_q.data <= pix8;
      if (!rst_n) begin
         pix_q.valid <= 1'b0;
         vs_q        <= 1'b0;
         vs_q2       <= 1'b0;
      end else begin
         // Other data types are dropped here
         pix_q.valid <= i_mipi.valid && (i_mipi.dtype == RAW10_DT);
         vs_q        <= i_mipi.vs;
         vs_q2       <= vs_q;
      end
   end

   assign o_pix = pix_q;

   // Frame boundary
   assign o_frame_end = vs_q2 & ~vs_q;

endmodule

// ==== hw/cam_pkg.sv ====
//////////////////////////////
// Shared widths, the RAW10 data type code and the bus structs of
// the camera capture path. Modules import it inside their body.
//////////////////////////////

package cam_pkg;

   // MIPI CSI-2 data type of RAW10
   localparam logic [5:0]  RAW10_DT   = 6'h2B;

   localparam int unsigned PPC        = 4;
   localparam int unsigned RAW_BITS   = 10;
   localparam int unsigned PIX_BITS   = 8;
   localparam int unsigned PIX_WORD_W = 32;
   localparam int unsigned DMA_DATA_W = 64;
   localparam int unsigned CNT_W      = 32;

   // One word from the MIPI receiver
   typedef struct packed {
      logic [63:0] data;
      logic [5:0]  dtype;
      logic        valid;
      logic        vs;
      logic        hs;
   } mipi_in_s;

   // Four 8-bit pixels packed into one word
   typedef struct packed {
      logic                  valid;
      logic [PIX_WORD_W-1:0] data;
   } pix_word_s;

   // Single-cycle events for the statistics block
   typedef struct packed {
      logic fifo_wr;
      logic dma_beat;
      logic fifo_overflow;
      logic fifo_underflow;
      logic frame_end;
   } stat_evt_s;

endpackage
